// ==== logic/nes_core_pkg.sv ====
/*
  shared definitions for the NES core wrapper
  bridge register map, controller key bits and video constants
  packed types for settings, pads, host keys and video buses
*/

package nes_core_pkg;

  ////////////////////
  // bridge bus

  localparam int bridge_addr_width = 32;
  localparam int bridge_data_width = 32;

  // settings register map
  localparam logic [bridge_addr_width-1:0] addr_reset         = 32'h0000_0050;
  localparam logic [bridge_addr_width-1:0] addr_hide_overscan = 32'h0000_0200;
  localparam logic [bridge_addr_width-1:0] addr_mask_edges    = 32'h0000_0204;
  localparam logic [bridge_addr_width-1:0] addr_extra_sprites = 32'h0000_0208;
  localparam logic [bridge_addr_width-1:0] addr_palette       = 32'h0000_020C;
  localparam logic [bridge_addr_width-1:0] addr_multitap      = 32'h0000_0300;
  localparam logic [bridge_addr_width-1:0] addr_lightgun      = 32'h0000_0304;
  localparam logic [bridge_addr_width-1:0] addr_aim_speed     = 32'h0000_0308;
  localparam logic [bridge_addr_width-1:0] addr_swap          = 32'h0000_030C;

  // length of the external reset pulse, in clk_74a cycles
  localparam logic [31:0] reset_hold_cycles = 32'h0010_0000;

  ////////////////////
  // controllers

  localparam int num_players = 4;
  localparam int key_width   = 16;
  localparam int sync_stages = 3;

  // bit positions in the host key word
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_a      = 4;
  localparam int key_b      = 5;
  localparam int key_select = 14;
  localparam int key_start  = 15;

  ////////////////////
  // video

  localparam int rgb_width         = 24;
  localparam int hs_delay_cycles   = 7;
  localparam int slot_overscan_bit = 13;

  // types
  typedef struct packed {
    logic       hide_overscan;
    logic [1:0] mask_vid_edges;
    logic       allow_extra_sprites;
    logic [2:0] selected_palette;
    logic       multitap_enabled;
    logic       lightgun_enabled;
    logic [7:0] lightgun_dpad_aim_speed;
    logic       swap_controllers;
    logic [1:0] reserved;
  } nes_settings_t;

  typedef struct packed {
    logic a;
    logic b;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
  } nes_pad_t;

  // player 1 sits at index 0
  typedef nes_pad_t [num_players-1:0] nes_pads_t;

  typedef logic [num_players-1:0][key_width-1:0] host_keys_t;

  typedef struct packed {
    logic                 hblank;
    logic                 vblank;
    logic                 hsync;
    logic                 vsync;
    logic [rgb_width-1:0] rgb;
  } core_video_t;

  typedef struct packed {
    logic                 de;
    logic                 hs;
    logic                 vs;
    logic [rgb_width-1:0] rgb;
  } scaler_video_t;

endpackage

// ==== logic/bridge_settings.sv ====
/*
  bridge write decoder for the core settings
  settings registers loaded from the low write-data bits
  external reset countdown started by a write to the reset address
*/

`timescale 1ns/1ps

module bridge_settings (
  input  logic                                         clk_74a,
  input  logic                                         pll_core_locked,
  input  logic                                         bridge_wr,
  input  logic [nes_core_pkg::bridge_addr_width-1:0]   bridge_addr,
  input  logic [nes_core_pkg::bridge_data_width-1:0]   bridge_wr_data,
  output nes_core_pkg::nes_settings_t                  settings,
  output logic                                         external_reset
);

  import nes_core_pkg::*;

  logic [31:0] reset_count;
  logic        reset_write;

  assign reset_write = bridge_wr && (bridge_addr == addr_reset);

  ////////////////////
  // settings registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_hide_overscan: begin
          settings.hide_overscan <= bridge_wr_data[0];
        end
        addr_mask_edges: begin
          settings.mask_vid_edges <= bridge_wr_data[1:0];
        end
        addr_extra_sprites: begin
          settings.allow_extra_sprites <= bridge_wr_data[0];
        end
        addr_palette: begin
          settings.selected_palette <= bridge_wr_data[2:0];
        end
        addr_multitap: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        addr_lightgun: begin
          settings.lightgun_enabled <= bridge_wr_data[0];
        end
        addr_aim_speed: begin
          settings.lightgun_dpad_aim_speed <= bridge_wr_data[7:0];
        end
        addr_swap: begin
          settings.swap_controllers <= bridge_wr_data[0];
        end
        default: begin
          // unmapped address, nothing to update
        end
      endcase
    end
  end

  ////////////////////
  // external reset countdown

  // a new reset write restarts the full count
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (reset_write) begin
      reset_count <= reset_hold_cycles;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 32'd1;
    end
  end

  assign external_reset = (reset_count != '0);

  // count only ever loads the hold value and then falls
  count_in_range: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    reset_count <= reset_hold_cycles
  );

endmodule

// ==== logic/pad_mapper.sv ====
/*
  controller key pipeline and NES pad mapping
  three register stages, then eight buttons picked per player
*/

`timescale 1ns/1ps

module pad_mapper (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  nes_core_pkg::host_keys_t host_keys,
  output nes_core_pkg::nes_pads_t  pads
);

  import nes_core_pkg::*;

  host_keys_t key_pipe [sync_stages];

  // pick the NES buttons out of one host key word
  function automatic nes_pad_t map_keys(input logic [key_width-1:0] keys);
    nes_pad_t pad;
    pad.a      = keys[key_a];
    pad.b      = keys[key_b];
    pad.select = keys[key_select];
    pad.start  = keys[key_start];
    pad.up     = keys[key_up];
    pad.down   = keys[key_down];
    pad.left   = keys[key_left];
    pad.right  = keys[key_right];
    return pad;
  endfunction

  function automatic nes_pads_t map_all(input host_keys_t keys);
    nes_pads_t mapped;
    for (int p = 0; p < num_players; p++) begin
      mapped[p] = map_keys(keys[p]);
    end
    return mapped;
  endfunction

  // full rate chain, a new sample enters every cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int i = 0; i < sync_stages; i++) begin
        key_pipe[i] <= '0;
      end
    end else begin
      key_pipe[0] <= host_keys;
      for (int i = 1; i < sync_stages; i++) begin
        key_pipe[i] <= key_pipe[i-1];
      end
    end
  end

  assign pads = map_all(key_pipe[sync_stages-1]);

  // pads trail the host keys by exactly the pipeline depth
  pads_follow_keys: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $past(pll_core_locked, sync_stages) |-> pads == map_all($past(host_keys, sync_stages))
  );

endmodule

// ==== logic/video_conditioner.sv ====
/*
  video conditioning between the emulation core and the scaler
  data enable from blanking, end of line slot word with overscan flag
  delayed single cycle hsync pulse and single cycle vsync pulse
*/

`timescale 1ns/1ps

module video_conditioner (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  nes_core_pkg::core_video_t   core_video,
  input  logic                        hide_overscan,
  output nes_core_pkg::scaler_video_t scaler_video
);

  import nes_core_pkg::*;

  logic                 de_in;
  logic [rgb_width-1:0] slot_word;

  // edge detect history
  logic                 hs_prev;
  logic                 vs_prev;
  logic                 de_prev;

  // hsync delay counter
  logic [2:0]           hs_delay;

  assign de_in = ~(core_video.hblank | core_video.vblank);

  // slot word sent right after the last active pixel of a line
  always_comb begin
    slot_word = '0;
    slot_word[slot_overscan_bit] = hide_overscan;
  end

  ////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      scaler_video <= '0;
      hs_prev      <= 1'b0;
      vs_prev      <= 1'b0;
      de_prev      <= 1'b0;
      hs_delay     <= '0;
    end else begin
      scaler_video.de <= de_in;

      if (de_in) begin
        scaler_video.rgb <= core_video.rgb;
      end else if (de_prev) begin
        scaler_video.rgb <= slot_word;
      end else begin
        scaler_video.rgb <= '0;
      end

      // hsync pushed back so it never lands on the vsync pulse
      if (!hs_prev && core_video.hsync) begin
        hs_delay <= 3'(hs_delay_cycles);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 3'd1;
      end

      scaler_video.hs <= (hs_delay == 3'd1);

      // rising edge only
      scaler_video.vs <= !vs_prev && core_video.vsync;

      hs_prev <= core_video.hsync;
      vs_prev <= core_video.vsync;
      de_prev <= de_in;
    end
  end

  ////////////////////
  // checks

  vs_single_cycle: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    scaler_video.vs |=> !scaler_video.vs
  );

  hs_single_cycle: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    scaler_video.hs |=> !scaler_video.hs
  );

  // only the slot cycle may carry data outside the active line
  rgb_quiet_in_blank: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (!scaler_video.de && !$past(scaler_video.de)) |-> (scaler_video.rgb == '0)
  );

endmodule

// ==== logic/core_top.sv ====
/*
  top level of the host facing wrapper
  settings decoder, controller mapper and video conditioner
*/

`timescale 1ns/1ps

module core_top (
  input  logic                                       clk_74a,
  input  logic                                       pll_core_locked,

  // bridge bus, writes only
  input  logic                                       bridge_wr,
  input  logic [nes_core_pkg::bridge_addr_width-1:0] bridge_addr,
  input  logic [nes_core_pkg::bridge_data_width-1:0] bridge_wr_data,

  // host controllers and core video
  input  nes_core_pkg::host_keys_t                   host_keys,
  input  nes_core_pkg::core_video_t                  core_video,

  // towards the core and the scaler
  output nes_core_pkg::nes_settings_t                settings,
  output logic                                       external_reset,
  output nes_core_pkg::nes_pads_t                    pads,
  output nes_core_pkg::scaler_video_t                scaler_video
);

  ////////////////////
  // settings

  bridge_settings i_bridge_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_wr       (bridge_wr),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .settings        (settings),
    .external_reset  (external_reset)
  );

  ////////////////////
  // controllers

  pad_mapper i_pad_mapper (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .host_keys       (host_keys),
    .pads            (pads)
  );

  ////////////////////
  // video

  // overscan flag rides along in the slot word
  video_conditioner i_video_conditioner (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_video      (core_video),
    .hide_overscan   (settings.hide_overscan),
    .scaler_video    (scaler_video)
  );

endmodule

// ==== tests/core_top_tb.sv ====
/*
  testbench for the NES core wrapper top level
  reference models for settings, reset request, pads and video
  concurrent assertions compare the DUT against them
*/

`timescale 1ns/1ps

module core_top_tb;

  import nes_core_pkg::*;

  localparam int num_tests      = 5;
  localparam int timeout_cycles = 4000;

  logic                     clk_74a;
  logic                     pll_core_locked;
  logic                     bridge_wr;
  logic [31:0]              bridge_addr;
  logic [31:0]              bridge_wr_data;
  host_keys_t               host_keys;
  core_video_t              core_video;
  nes_settings_t            settings;
  logic                     external_reset;
  nes_pads_t                pads;
  scaler_video_t            scaler_video;

  integer                   seed = 32'h3832;
  int                       active_test = -1;
  int                       cycle_count = 0;
  int                       fail_count [num_tests];
  string                    test_names [num_tests] = '{"settings_writes", "reset_request",
                                                       "pad_mapping", "data_enable", "sync_pulses"};
  logic [31:0]              settings_addrs [8] = '{addr_hide_overscan, addr_mask_edges,
                                                   addr_extra_sprites, addr_palette, addr_multitap,
                                                   addr_lightgun, addr_aim_speed, addr_swap};

  // reference state, all of it sampled at the rising edge
  nes_settings_t            settings_model;
  logic [31:0]              reset_age;
  host_keys_t               keys_hist [sync_stages];
  logic [1:0]               de_hist;
  logic [rgb_width-1:0]     rgb_hist;
  logic                     overscan_hist;
  logic                     hsync_last;
  logic                     vsync_last;
  logic [hs_delay_cycles:0] hs_rise_hist;
  logic                     vs_rise_hist;

  core_top i_dut (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_wr       (bridge_wr),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .host_keys       (host_keys),
    .core_video      (core_video),
    .settings        (settings),
    .external_reset  (external_reset),
    .pads            (pads),
    .scaler_video    (scaler_video)
  );

  initial clk_74a = 1'b0;
  always #10 clk_74a = ~clk_74a;

  ////////////////////
  // reference models

  function automatic nes_settings_t apply_write(input nes_settings_t cur, input logic [31:0] addr,
                                                input logic [31:0] data);
    nes_settings_t next;
    next = cur;
    case (addr)
      addr_hide_overscan: next.hide_overscan = data[0];
      addr_mask_edges:    next.mask_vid_edges = data[1:0];
      addr_extra_sprites: next.allow_extra_sprites = data[0];
      addr_palette:       next.selected_palette = data[2:0];
      addr_multitap:      next.multitap_enabled = data[0];
      addr_lightgun:      next.lightgun_enabled = data[0];
      addr_aim_speed:     next.lightgun_dpad_aim_speed = data[7:0];
      addr_swap:          next.swap_controllers = data[0];
      default:            next = cur;
    endcase
    return next;
  endfunction

  function automatic nes_pads_t expected_pads(input host_keys_t keys);
    nes_pads_t result;
    for (int p = 0; p < num_players; p++) begin
      result[p] = {keys[p][key_a], keys[p][key_b], keys[p][key_select], keys[p][key_start],
                   keys[p][key_up], keys[p][key_down], keys[p][key_left], keys[p][key_right]};
    end
    return result;
  endfunction

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings_model <= '0;
      reset_age      <= '0;
      keys_hist      <= '{default: '0};
      de_hist        <= '0;
      rgb_hist       <= '0;
      overscan_hist  <= 1'b0;
      hsync_last     <= 1'b0;
      vsync_last     <= 1'b0;
      hs_rise_hist   <= '0;
      vs_rise_hist   <= 1'b0;
    end else begin
      if (bridge_wr) begin
        settings_model <= apply_write(settings_model, bridge_addr, bridge_wr_data);
      end
      // age 1 is the first cycle of the external reset
      if (bridge_wr && bridge_addr == addr_reset) begin
        reset_age <= 32'd1;
      end else if (reset_age != '0 && reset_age <= reset_hold_cycles) begin
        reset_age <= reset_age + 32'd1;
      end
      keys_hist[0] <= host_keys;
      for (int i = 1; i < sync_stages; i++) begin
        keys_hist[i] <= keys_hist[i-1];
      end
      de_hist       <= {de_hist[0], !(core_video.hblank || core_video.vblank)};
      rgb_hist      <= core_video.rgb;
      overscan_hist <= settings_model.hide_overscan;
      hs_rise_hist  <= {hs_rise_hist[hs_delay_cycles-1:0], core_video.hsync && !hsync_last};
      vs_rise_hist  <= core_video.vsync && !vsync_last;
      hsync_last    <= core_video.hsync;
      vsync_last    <= core_video.vsync;
    end
  end

  logic                 reset_expected;
  logic [rgb_width-1:0] rgb_expected;

  assign reset_expected = (reset_age != '0) && (reset_age <= reset_hold_cycles);

  // slot word goes out in the cycle after de falls
  always_comb begin
    rgb_expected = '0;
    if (de_hist[0]) begin
      rgb_expected = rgb_hist;
    end else if (de_hist[1]) begin
      rgb_expected[slot_overscan_bit] = overscan_hist;
    end
  end

  ////////////////////
  // checks

  settings_match: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (active_test == 0) |-> (settings == settings_model))
  else begin
    fail_count[0]++;
    $display("[ERROR] %s expected %h actual %h", test_names[0], $sampled(settings_model),
             $sampled(settings));
  end

  reset_match: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (active_test == 1) |-> (external_reset == reset_expected))
  else begin
    fail_count[1]++;
    $display("[ERROR] %s expected %b actual %b", test_names[1], $sampled(reset_expected),
             $sampled(external_reset));
  end

  pads_match: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (active_test == 2) |-> (pads == expected_pads(keys_hist[sync_stages-1])))
  else begin
    fail_count[2]++;
    $display("[ERROR] %s expected %h actual %h", test_names[2],
             expected_pads($sampled(keys_hist[sync_stages-1])), $sampled(pads));
  end

  video_match: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (active_test == 3) |-> ({scaler_video.de, scaler_video.rgb} == {de_hist[0], rgb_expected}))
  else begin
    fail_count[3]++;
    $display("[ERROR] %s expected %h actual %h", test_names[3],
             $sampled({de_hist[0], rgb_expected}), $sampled({scaler_video.de, scaler_video.rgb}));
  end

  sync_match: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (active_test == 4) |->
    ({scaler_video.hs, scaler_video.vs} == {hs_rise_hist[hs_delay_cycles], vs_rise_hist}))
  else begin
    fail_count[4]++;
    $display("[ERROR] %s expected %b actual %b", test_names[4],
             $sampled({hs_rise_hist[hs_delay_cycles], vs_rise_hist}),
             $sampled({scaler_video.hs, scaler_video.vs}));
  end

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_wr      <= 1'b1;
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
  endtask

  task automatic start_test(input int idx);
    @(posedge clk_74a);
    active_test <= idx;
  endtask

  task automatic finish_test(input int idx);
    repeat (sync_stages + 2) @(posedge clk_74a);
    active_test <= -1;
    @(posedge clk_74a);
    $display("test %s finished with %0d errors", test_names[idx], fail_count[idx]);
  endtask

  initial begin
    int tests_failed;
    tests_failed      = 0;
    pll_core_locked   = 1'b0;
    bridge_wr         = 1'b0;
    bridge_addr       = '0;
    bridge_wr_data    = '0;
    host_keys         = '0;
    core_video        = '0;
    core_video.hblank = 1'b1;
    core_video.vblank = 1'b1;
    repeat (4) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    start_test(0);
    foreach (settings_addrs[i]) begin
      write_reg(settings_addrs[i], $random(seed));
    end
    write_reg(32'h0000_0210, $random(seed));
    finish_test(0);

    start_test(1);
    write_reg(addr_reset, $random(seed));
    repeat (200) @(posedge clk_74a);
    finish_test(1);

    start_test(2);
    repeat (100) begin
      @(posedge clk_74a);
      host_keys <= {$random(seed), $random(seed)};
    end
    finish_test(2);

    // one active line per value of hide overscan
    start_test(3);
    for (int hov = 0; hov < 2; hov++) begin
      write_reg(addr_hide_overscan, hov);
      repeat (32) begin
        @(posedge clk_74a);
        core_video.hblank <= 1'b0;
        core_video.vblank <= 1'b0;
        core_video.rgb    <= rgb_width'($random(seed));
      end
      repeat (8) begin
        @(posedge clk_74a);
        core_video.hblank <= 1'b1;
        core_video.rgb    <= rgb_width'($random(seed));
      end
    end
    finish_test(3);

    start_test(4);
    @(posedge clk_74a);
    core_video.vsync <= 1'b1;
    repeat (20) @(posedge clk_74a);
    core_video.vsync <= 1'b0;
    core_video.hsync <= 1'b1;
    repeat (20) @(posedge clk_74a);
    core_video.hsync <= 1'b0;
    finish_test(4);

    foreach (fail_count[i]) begin
      if (fail_count[i] != 0) begin
        tests_failed++;
      end
    end
    $display("tests passed %0d, tests failed %0d", num_tests - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== core_top.f ====
logic/nes_core_pkg.sv
logic/bridge_settings.sv
logic/pad_mapper.sv
logic/video_conditioner.sv
logic/core_top.sv
tests/core_top_tb.sv
